// File: source/tti_pkg.sv
// queue-side widths, FIFO depths and the TX descriptor type.
`default_nettype none

package tti_pkg;

  localparam int unsigned DataWordWidth = 32;  // host data word.
  localparam int unsigned DescFifoDepth = 4;
  localparam int unsigned DataFifoDepth = 16;
  // fill count of a data FIFO, 0 to DataFifoDepth.
  localparam int unsigned DataCountWidth = 5;

  // one descriptor occupies exactly one host word.
  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] data_len;  // bytes in the transfer.
  } tx_desc_t;

endpackage

`default_nettype wire

// File: source/tx_bus_pkg.sv
// lane count, host write bundle and bus-side byte bundle.
`default_nettype none

package tx_bus_pkg;

  localparam int unsigned NumLanes = 4;  // virtual targets.
  localparam int unsigned LaneIdxWidth = 2;

  typedef struct packed {
    logic [LaneIdxWidth-1:0] lane;
    logic is_desc;  // descriptor FIFO when set, data FIFO when clear.
    logic [tti_pkg::DataWordWidth-1:0] word;
  } host_wr_t;

  // byte towards the target FSM, last sets the T-bit.
  typedef struct packed {
    logic [7:0] data;
    logic last;
  } tx_byte_t;

endpackage

`default_nettype wire

// File: source/sync_fifo.sv
// synchronous FIFO with a typed payload and a fill count.
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int unsigned Depth = 4,
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int unsigned CountWidth = $clog2(Depth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  payload_t              push_data_i,
  input  logic                  pop_i,
  output payload_t              pop_data_o,
  output logic                  empty_o,
  output logic                  full_o,
  output logic [CountWidth-1:0] count_o
);

  payload_t mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CountWidth-1:0] count_q;

  assign empty_o = (count_q == '0);
  assign full_o = (count_q == CountWidth'(Depth));
  assign count_o = count_q;
  assign pop_data_o = mem_q[rd_ptr_q];  // head is visible without a pop.

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // the host checks full before writing.
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: source/word_to_byte.sv
// unpacks host data words into bytes, least significant byte first.
`default_nettype none

module word_to_byte (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               word_valid_i,
  input  logic [tti_pkg::DataWordWidth-1:0]  word_i,
  output logic                               word_pop_o,
  output logic [7:0]                         byte_o,
  output logic                               byte_valid_o,
  input  logic                               byte_ready_i,
  input  logic                               flush_i,
  output logic                               holding_o
);

  logic [tti_pkg::DataWordWidth-1:0] word_q;
  logic [1:0] idx_q;  // next byte to offer.
  logic holding_q;

  // load a new word only once the previous one is fully drained.
  assign word_pop_o = !holding_q && word_valid_i && !flush_i;
  assign byte_o = word_q[8*idx_q +: 8];
  assign byte_valid_o = holding_q;
  assign holding_o = holding_q;

  always_ff @(posedge clk_i) begin
    if (word_pop_o) begin
      word_q <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holding_q <= 1'b0;
      idx_q <= '0;
    end else if (flush_i) begin
      holding_q <= 1'b0;  // leftover bytes are dropped.
      idx_q <= '0;
    end else if (word_pop_o) begin
      holding_q <= 1'b1;
      idx_q <= '0;
    end else if (byte_valid_o && byte_ready_i) begin
      idx_q <= idx_q + 1'b1;
      if (idx_q == 2'd3) begin
        holding_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/descriptor_tx.sv
// TX descriptor handler with byte counting, last marking and abort flushing.
`default_nettype none

module descriptor_tx (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // descriptor FIFO.
  input  logic                                 desc_empty_i,
  input  tti_pkg::tx_desc_t                    desc_i,
  output logic                                 desc_pop_o,
  // data FIFO and byte converter.
  input  logic [tti_pkg::DataCountWidth-1:0]   data_count_i,
  input  logic                                 conv_holding_i,
  input  logic [7:0]                           conv_byte_i,
  input  logic                                 conv_valid_i,
  output logic                                 conv_ready_o,
  output logic                                 conv_flush_o,
  // target FSM.
  input  logic                                 tx_start_i,
  input  logic                                 tx_abort_i,
  input  logic                                 recovery_mode_enter_i,
  output tx_bus_pkg::tx_byte_t                 tx_byte_o,
  output logic                                 tx_byte_valid_o,
  input  logic                                 tx_byte_ready_i
);

  typedef enum logic [1:0] {
    StIdle,
    StWait,   // descriptor held, waiting for its data.
    StSend,
    StFlush   // dropping the rest of an aborted transfer.
  } state_e;

  state_e state_q, state_d;
  tti_pkg::tx_desc_t desc_q;
  logic [15:0] byte_cnt_q;
  logic [15:0] len_words;
  logic [15:0] avail_words;
  logic cancel;
  logic data_ready;
  logic byte_xfer;
  logic last_byte;

  assign cancel = tx_abort_i | recovery_mode_enter_i;
  assign desc_pop_o = (state_q == StIdle) && tx_start_i && !desc_empty_i && !cancel;

  // the word held in the converter counts towards the data on hand.
  assign len_words = 16'((17'(desc_q.data_len) + 17'd3) >> 2);
  assign avail_words = 16'(data_count_i) + 16'(conv_holding_i);
  assign data_ready = (avail_words >= len_words);

  assign tx_byte_valid_o = (state_q == StSend) && conv_valid_i;
  assign tx_byte_o.data = conv_byte_i;
  assign tx_byte_o.last = tx_byte_valid_o && (byte_cnt_q == 16'd1);

  assign conv_ready_o = ((state_q == StSend) && tx_byte_ready_i) || (state_q == StFlush);
  assign byte_xfer = conv_valid_i && conv_ready_o;
  assign last_byte = byte_xfer && (byte_cnt_q == 16'd1);
  assign conv_flush_o = last_byte;  // next descriptor starts on a word boundary.

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (desc_pop_o) state_d = StWait;
      end
      StWait: begin
        if (cancel) begin
          state_d = StIdle;
        end else if (data_ready) begin
          state_d = (desc_q.data_len == '0) ? StIdle : StSend;
        end
      end
      StSend: begin
        if (last_byte) begin
          state_d = StIdle;
        end else if (cancel) begin
          state_d = StFlush;
        end
      end
      StFlush: begin
        if (last_byte) state_d = StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (desc_pop_o) begin
      desc_q <= desc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      byte_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == StWait && state_d == StSend) begin
        byte_cnt_q <= desc_q.data_len;
      end else if (byte_xfer) begin
        byte_cnt_q <= byte_cnt_q - 1'b1;
      end
    end
  end

  // an accepted last byte ends the transfer and drops the converter's padding.
  a_last_ends_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && tx_byte_ready_i && tx_byte_o.last
    |=> !tx_byte_valid_o && !conv_holding_i);
  // the converter never offers more bytes than the descriptor asked for.
  a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_xfer |-> byte_cnt_q != '0);

endmodule

`default_nettype wire

// File: source/tx_lane.sv
// one virtual target: descriptor and data FIFOs, byte converter and handler.
`default_nettype none

module tx_lane (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               desc_push_i,
  input  logic                               data_push_i,
  input  logic [tti_pkg::DataWordWidth-1:0]  push_word_i,
  output logic                               desc_full_o,
  output logic                               data_full_o,
  output logic                               desc_avail_o,
  input  logic                               tx_start_i,
  input  logic                               tx_abort_i,
  input  logic                               recovery_mode_enter_i,
  output tx_bus_pkg::tx_byte_t               tx_byte_o,
  output logic                               tx_byte_valid_o,
  input  logic                               tx_byte_ready_i
);

  tti_pkg::tx_desc_t desc_head;
  logic desc_empty, desc_pop;
  logic [tti_pkg::DataWordWidth-1:0] data_head;
  logic data_empty, data_pop;
  logic [tti_pkg::DataCountWidth-1:0] data_count;
  logic [7:0] conv_byte;
  logic conv_valid, conv_ready, conv_flush, conv_holding;

  assign desc_avail_o = !desc_empty;

  sync_fifo #(
    .payload_t (tti_pkg::tx_desc_t),
    .Depth     (tti_pkg::DescFifoDepth)
  ) i_desc_fifo (
    .clk_i, .rst_ni,
    .push_i      (desc_push_i),
    .push_data_i (tti_pkg::tx_desc_t'(push_word_i)),
    .pop_i       (desc_pop),
    .pop_data_o  (desc_head),
    .empty_o     (desc_empty),
    .full_o      (desc_full_o),
    .count_o     ()
  );

  sync_fifo #(
    .payload_t (logic [tti_pkg::DataWordWidth-1:0]),
    .Depth     (tti_pkg::DataFifoDepth)
  ) i_data_fifo (
    .clk_i, .rst_ni,
    .push_i      (data_push_i),
    .push_data_i (push_word_i),
    .pop_i       (data_pop),
    .pop_data_o  (data_head),
    .empty_o     (data_empty),
    .full_o      (data_full_o),
    .count_o     (data_count)
  );

  word_to_byte i_word_to_byte (
    .clk_i, .rst_ni,
    .word_valid_i (!data_empty),
    .word_i       (data_head),
    .word_pop_o   (data_pop),
    .byte_o       (conv_byte),
    .byte_valid_o (conv_valid),
    .byte_ready_i (conv_ready),
    .flush_i      (conv_flush),
    .holding_o    (conv_holding)
  );

  descriptor_tx i_descriptor_tx (
    .clk_i, .rst_ni,
    .desc_empty_i          (desc_empty),
    .desc_i                (desc_head),
    .desc_pop_o            (desc_pop),
    .data_count_i          (data_count),
    .conv_holding_i        (conv_holding),
    .conv_byte_i           (conv_byte),
    .conv_valid_i          (conv_valid),
    .conv_ready_o          (conv_ready),
    .conv_flush_o          (conv_flush),
    .tx_start_i, .tx_abort_i, .recovery_mode_enter_i,
    .tx_byte_o, .tx_byte_valid_o, .tx_byte_ready_i
  );

endmodule

`default_nettype wire

// File: source/host_write_demux.sv
// routes host writes to one lane's descriptor or data FIFO.
`default_nettype none

module host_write_demux (
  input  logic                               host_wr_valid_i,
  input  tx_bus_pkg::host_wr_t               host_wr_i,
  input  logic [tx_bus_pkg::NumLanes-1:0]    lane_desc_full_i,
  input  logic [tx_bus_pkg::NumLanes-1:0]    lane_data_full_i,
  output logic [tx_bus_pkg::NumLanes-1:0]    desc_push_o,
  output logic [tx_bus_pkg::NumLanes-1:0]    data_push_o,
  output logic [tti_pkg::DataWordWidth-1:0]  push_word_o,
  output logic [tx_bus_pkg::NumLanes-1:0]    host_full_o
);

  // exactly one strobe per valid write.
  always_comb begin
    desc_push_o = '0;
    data_push_o = '0;
    if (host_wr_valid_i) begin
      if (host_wr_i.is_desc) begin
        desc_push_o[host_wr_i.lane] = 1'b1;
      end else begin
        data_push_o[host_wr_i.lane] = 1'b1;
      end
    end
  end

  assign push_word_o = host_wr_i.word;  // shared by all lanes.

  // full of whichever FIFO kind the current write targets.
  assign host_full_o = host_wr_i.is_desc ? lane_desc_full_i : lane_data_full_i;

endmodule

`default_nettype wire

// File: source/tx_byte_mux.sv
// steers target FSM control to the selected lane and returns its bytes.
`default_nettype none

module tx_byte_mux (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [tx_bus_pkg::LaneIdxWidth-1:0]           tx_lane_sel_i,
  input  logic                                          tx_start_i,
  input  logic                                          tx_abort_i,
  input  logic                                          tx_byte_ready_i,
  output logic [tx_bus_pkg::NumLanes-1:0]               lane_start_o,
  output logic [tx_bus_pkg::NumLanes-1:0]               lane_abort_o,
  output logic [tx_bus_pkg::NumLanes-1:0]               lane_ready_o,
  input  tx_bus_pkg::tx_byte_t [tx_bus_pkg::NumLanes-1:0] lane_byte_i,
  input  logic [tx_bus_pkg::NumLanes-1:0]               lane_valid_i,
  output tx_bus_pkg::tx_byte_t                          tx_byte_o,
  output logic                                          tx_byte_valid_o
);

  // unselected lanes see no start, abort or ready.
  always_comb begin
    lane_start_o = '0;
    lane_abort_o = '0;
    lane_ready_o = '0;
    lane_start_o[tx_lane_sel_i] = tx_start_i;
    lane_abort_o[tx_lane_sel_i] = tx_abort_i;
    lane_ready_o[tx_lane_sel_i] = tx_byte_ready_i;
  end

  assign tx_byte_o = lane_byte_i[tx_lane_sel_i];
  assign tx_byte_valid_o = lane_valid_i[tx_lane_sel_i];

  // switching lanes under a pending byte would lose it.
  a_sel_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && !tx_byte_ready_i |=> $stable(tx_lane_sel_i));

endmodule

`default_nettype wire

// File: source/i3c_tx_top.sv
// I3C target TTI transmit path with one lane per virtual target.
`default_nettype none

module i3c_tx_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 host_wr_valid_i,
  input  tx_bus_pkg::host_wr_t                 host_wr_i,
  output logic [tx_bus_pkg::NumLanes-1:0]      host_full_o,
  input  logic [tx_bus_pkg::LaneIdxWidth-1:0]  tx_lane_sel_i,
  input  logic                                 tx_start_i,
  input  logic                                 tx_abort_i,
  input  logic                                 recovery_mode_enter_i,
  output logic [tx_bus_pkg::NumLanes-1:0]      tx_desc_avail_o,
  output tx_bus_pkg::tx_byte_t                 tx_byte_o,
  output logic                                 tx_byte_valid_o,
  input  logic                                 tx_byte_ready_i
);

  localparam int unsigned NumLanes = tx_bus_pkg::NumLanes;

  logic [NumLanes-1:0] desc_push, data_push, desc_full, data_full;
  logic [tti_pkg::DataWordWidth-1:0] push_word;
  logic [NumLanes-1:0] lane_start, lane_abort, lane_ready, lane_valid;
  tx_bus_pkg::tx_byte_t [NumLanes-1:0] lane_byte;

  host_write_demux i_host_write_demux (
    .host_wr_valid_i, .host_wr_i,
    .lane_desc_full_i (desc_full),
    .lane_data_full_i (data_full),
    .desc_push_o      (desc_push),
    .data_push_o      (data_push),
    .push_word_o      (push_word),
    .host_full_o
  );

  for (genvar i = 0; i < NumLanes; i++) begin : g_lane
    tx_lane i_tx_lane (
      .clk_i, .rst_ni,
      .desc_push_i           (desc_push[i]),
      .data_push_i           (data_push[i]),
      .push_word_i           (push_word),
      .desc_full_o           (desc_full[i]),
      .data_full_o           (data_full[i]),
      .desc_avail_o          (tx_desc_avail_o[i]),
      .tx_start_i            (lane_start[i]),
      .tx_abort_i            (lane_abort[i]),
      .recovery_mode_enter_i (recovery_mode_enter_i),  // all lanes.
      .tx_byte_o             (lane_byte[i]),
      .tx_byte_valid_o       (lane_valid[i]),
      .tx_byte_ready_i       (lane_ready[i])
    );
  end

  tx_byte_mux i_tx_byte_mux (
    .clk_i, .rst_ni,
    .tx_lane_sel_i, .tx_start_i, .tx_abort_i, .tx_byte_ready_i,
    .lane_start_o (lane_start),
    .lane_abort_o (lane_abort),
    .lane_ready_o (lane_ready),
    .lane_byte_i  (lane_byte),
    .lane_valid_i (lane_valid),
    .tx_byte_o, .tx_byte_valid_o
  );

endmodule

`default_nettype wire

// File: testbench/tb_i3c_tx.sv
// testbench for the I3C TX path with stimulus, expected-byte queues and checking assertions.
`default_nettype none

module tb_i3c_tx;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumLanes = tx_bus_pkg::NumLanes;
  localparam int TotalBytes = 116;  // bytes moved over all tests.
  localparam int NumDescs = 15;
  localparam int TimeoutCycles = 16 + 4 * TotalBytes + 50 * NumDescs;

  logic clk_i, rst_ni;
  logic host_wr_valid_i;
  tx_bus_pkg::host_wr_t host_wr_i;
  logic [NumLanes-1:0] host_full_o, tx_desc_avail_o;
  logic [tx_bus_pkg::LaneIdxWidth-1:0] tx_lane_sel_i;
  logic tx_start_i, tx_abort_i, recovery_mode_enter_i;
  logic tx_byte_ready_i = 1'b0;
  tx_bus_pkg::tx_byte_t tx_byte_o;
  logic tx_byte_valid_o;

  integer seed = 32'hbc8d;
  logic [31:0] rnd;
  logic [8:0] exp_q [NumLanes][$];  // {data, last} per expected byte.
  logic [8:0] exp_head;
  logic exp_any, rand_ready, hold_ready, avail_chk;
  logic [NumLanes-1:0] avail_model, full_model;
  int pend [NumLanes];
  int acc_total, err_cnt, err_base, n_tests, n_pass, cycles;
  string test_name;

  i3c_tx_top i_i3c_tx_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ready is random, forced low around aborts, or held high.
  always @(posedge clk_i) begin
    if (hold_ready) begin
      tx_byte_ready_i <= 1'b0;
    end else if (rand_ready) begin
      rnd = $random(seed);
      tx_byte_ready_i <= rnd[0] | rnd[1];
    end else begin
      tx_byte_ready_i <= 1'b1;
    end
  end

  // accepted bytes leave the model queue of the selected lane.
  always @(posedge clk_i) begin
    if (rst_ni && tx_byte_valid_o && tx_byte_ready_i && exp_q[tx_lane_sel_i].size() > 0) begin
      void'(exp_q[tx_lane_sel_i].pop_front());
      acc_total <= acc_total + 1;
    end
  end

  always @(negedge clk_i) begin
    exp_any = exp_q[tx_lane_sel_i].size() != 0;
    exp_head = exp_any ? exp_q[tx_lane_sel_i][0] : '0;
  end

  a_byte: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && tx_byte_ready_i |-> exp_any && tx_byte_o == exp_head)
    else begin
      $display("error %s: byte expected %h actual %h", test_name, exp_head,
               $sampled(tx_byte_o));
      err_cnt++;
    end
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && !tx_byte_ready_i && !tx_abort_i && !recovery_mode_enter_i
    |=> tx_byte_valid_o && $stable(tx_byte_o))
    else begin
      $display("%s: byte or valid changed while the byte was stalled", test_name);
      err_cnt++;
    end
  a_avail: assert property (@(posedge clk_i) disable iff (!rst_ni)
    avail_chk |-> tx_desc_avail_o == avail_model)
    else begin
      $display("error %s: desc_avail expected %b actual %b", test_name, avail_model,
               $sampled(tx_desc_avail_o));
      err_cnt++;
    end
  a_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    avail_chk |-> host_full_o == full_model)
    else begin
      $display("error %s: host_full expected %b actual %b", test_name, full_model,
               $sampled(host_full_o));
      err_cnt++;
    end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic host_write(input int lane, input logic is_desc, input logic [31:0] word);
    @(posedge clk_i);
    host_wr_valid_i <= 1'b1;
    host_wr_i.lane <= 2'(lane);
    host_wr_i.is_desc <= is_desc;
    host_wr_i.word <= word;
  endtask

  // queues one descriptor with random words and adds its bytes to the model LSB first.
  task automatic queue_desc(input int lane, input int len);
    logic [31:0] w;
    host_write(lane, 1'b1, {16'h0, 16'(len)});
    for (int i = 0; i < (len + 3) / 4; i++) begin
      w = $random(seed);
      host_write(lane, 1'b0, w);
      for (int b = 0; b < 4; b++) begin
        if (4 * i + b < len) exp_q[lane].push_back({w[8*b +: 8], 4 * i + b == len - 1});
      end
    end
    @(posedge clk_i);
    host_wr_valid_i <= 1'b0;
    pend[lane]++;
  endtask

  // descriptor FIFO levels against the pending count, full seen on a descriptor write.
  task automatic check_flags();
    for (int l = 0; l < NumLanes; l++) begin
      avail_model[l] = pend[l] > 0;
      full_model[l] = pend[l] >= tti_pkg::DescFifoDepth;
    end
    @(posedge clk_i);
    host_wr_i.is_desc <= 1'b1;
    avail_chk <= 1'b1;
    @(posedge clk_i);
    avail_chk <= 1'b0;
  endtask

  task automatic run_xfer(input int lane, input int nbytes, input int ndesc);
    int base;
    base = acc_total;
    @(posedge clk_i);
    tx_lane_sel_i <= 2'(lane);
    tx_start_i <= 1'b1;
    while (acc_total < base + nbytes) @(posedge clk_i);
    tx_start_i <= 1'b0;
    pend[lane] -= ndesc;
    repeat (4) @(posedge clk_i);
  endtask

  // cuts the first descriptor after n bytes, by abort or by recovery entry.
  task automatic cut_xfer(input int lane, input int len, input int n, input int next_len,
                          input logic recovery);
    int base;
    base = acc_total;
    @(posedge clk_i);
    tx_lane_sel_i <= 2'(lane);
    tx_start_i <= 1'b1;
    while (acc_total < base + n) @(posedge clk_i);
    hold_ready <= 1'b1;
    @(posedge clk_i);
    if (recovery) recovery_mode_enter_i <= 1'b1;
    else tx_abort_i <= 1'b1;
    @(posedge clk_i);
    tx_abort_i <= 1'b0;
    recovery_mode_enter_i <= 1'b0;
    hold_ready <= 1'b0;
    repeat (len - (acc_total - base)) void'(exp_q[lane].pop_front());
    base = acc_total;
    while (acc_total < base + next_len) @(posedge clk_i);
    tx_start_i <= 1'b0;
    pend[lane] -= 2;
    repeat (4) @(posedge clk_i);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_base = err_cnt;
  endtask

  task automatic end_test();
    n_tests++;
    if (err_cnt == err_base) n_pass++;
    $display("test %s: %s", test_name, (err_cnt == err_base) ? "ok" : "failed");
  endtask

  initial begin
    rst_ni = 1'b0;
    host_wr_valid_i = 1'b0;
    host_wr_i = '0;
    tx_lane_sel_i = '0;
    tx_start_i = 1'b0;
    tx_abort_i = 1'b0;
    recovery_mode_enter_i = 1'b0;
    rand_ready = 1'b0;
    hold_ready = 1'b0;
    avail_chk = 1'b0;
    avail_model = '0;
    full_model = '0;
    for (int l = 0; l < NumLanes; l++) pend[l] = 0;
    acc_total = 0;
    err_cnt = 0;
    n_tests = 0;
    n_pass = 0;
    cycles = 0;
    test_name = "reset";
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_flags();

    begin_test("word_multiple");
    queue_desc(0, 8);
    run_xfer(0, 8, 1);
    end_test();

    begin_test("odd_length");
    queue_desc(0, 5);
    queue_desc(0, 7);
    run_xfer(0, 12, 2);
    end_test();

    begin_test("lane_select");
    queue_desc(1, 4);
    queue_desc(2, 6);
    queue_desc(3, 3);
    check_flags();
    run_xfer(2, 6, 1);
    check_flags();
    run_xfer(1, 4, 1);
    run_xfer(3, 3, 1);
    check_flags();
    end_test();

    begin_test("random_ready");
    queue_desc(1, 40);
    rand_ready <= 1'b1;
    run_xfer(1, 40, 1);
    rand_ready <= 1'b0;
    end_test();

    begin_test("abort");
    queue_desc(1, 12);
    queue_desc(1, 6);
    cut_xfer(1, 12, 3, 6, 1'b0);
    end_test();

    begin_test("recovery");
    queue_desc(2, 12);
    queue_desc(2, 5);
    cut_xfer(2, 12, 5, 5, 1'b1);
    check_flags();
    end_test();

    begin_test("desc_full");
    for (int d = 0; d < tti_pkg::DescFifoDepth; d++) queue_desc(0, 2);
    check_flags();
    run_xfer(0, 8, 4);
    check_flags();
    end_test();

    begin_test("empty_start");
    @(posedge clk_i);
    tx_lane_sel_i <= 2'd3;
    tx_start_i <= 1'b1;
    repeat (20) @(posedge clk_i);
    tx_start_i <= 1'b0;
    check_flags();
    end_test();

    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests, n_pass,
             n_tests - n_pass, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: i3c_tx.f
source/tti_pkg.sv
source/tx_bus_pkg.sv
source/sync_fifo.sv
source/word_to_byte.sv
source/descriptor_tx.sv
source/tx_lane.sv
source/host_write_demux.sv
source/tx_byte_mux.sv
source/i3c_tx_top.sv
testbench/tb_i3c_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the I3C TX testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  --top-module tb_i3c_tx \
  -f i3c_tx.f \
  -o sim_i3c_tx

./obj_dir/sim_i3c_tx | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi
